// ==== common/rob_pkg.sv ====
// reorder buffer shared definitions
// widths, slot index and tag types
// dispatch, completion, head view and commit records
package rob_pkg;

	localparam int ROB_DEPTH = 8; // entries per thread, power of two
	localparam int INDEX_BITS = $clog2(ROB_DEPTH);
	localparam int PC_BITS = 64;
	localparam int ARN_BITS = 5; // architectural register number
	localparam int PRN_BITS = 6; // physical register number, 64 entry prf

	typedef logic [INDEX_BITS-1:0] rob_index_t;

	typedef struct packed {
		logic thread;
		rob_index_t index;
	} rob_tag_t;

	typedef struct packed {
		logic [PC_BITS-1:0] pc;
		logic [ARN_BITS-1:0] arn_dest;
		logic [PRN_BITS-1:0] prn_dest;
		logic is_branch;
	} rob_entry_t;

	// up to two instructions of one thread per cycle
	typedef struct packed {
		logic thread;
		logic valid_0;
		logic valid_1; // only together with valid_0
		rob_entry_t entry_0;
		rob_entry_t entry_1;
	} dispatch_t;

	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		logic mispredict;
		logic [PC_BITS-1:0] target_pc;
	} complete_t;

	// one slot as seen by the commit logic
	typedef struct packed {
		logic ready; // occupied and done
		rob_entry_t entry;
		logic mispredict;
		logic [PC_BITS-1:0] target_pc;
	} head_slot_t;

	typedef struct packed {
		head_slot_t head;
		head_slot_t next; // entry right behind the head
	} head_view_t;

	typedef struct packed {
		logic valid;
		logic thread;
		rob_entry_t entry;
		logic mispredict;
		logic [PC_BITS-1:0] target_pc;
	} commit_t;

endpackage

// ==== design/rob_top.sv ====
`timescale 1ns/1ps
// two-thread reorder buffer top level
// one queue per thread plus the shared commit selector
module rob_top (
	input logic clock,
	input logic reset,
	input rob_pkg::dispatch_t dispatch,
	input rob_pkg::complete_t complete_a,
	input rob_pkg::complete_t complete_b,
	output rob_pkg::rob_tag_t tag_0,
	output rob_pkg::rob_tag_t tag_1,
	output rob_pkg::commit_t commit_0,
	output rob_pkg::commit_t commit_1,
	output logic full_t0,
	output logic full_t1
);

	rob_pkg::head_view_t head_t0;
	rob_pkg::head_view_t head_t1;
	rob_pkg::rob_tag_t t0_tag_0;
	rob_pkg::rob_tag_t t0_tag_1;
	rob_pkg::rob_tag_t t1_tag_0;
	rob_pkg::rob_tag_t t1_tag_1;
	logic [1:0] retire_t0;
	logic [1:0] retire_t1;
	logic squash_t0;
	logic squash_t1;
	logic squash_any;

	rob_thread_queue #(.THREAD_ID(1'b0)) queue_t0 (
		.clock(clock),
		.reset(reset),
		.dispatch(dispatch),
		.squash_any(squash_any),
		.complete_a(complete_a),
		.complete_b(complete_b),
		.retire_count(retire_t0),
		.squash(squash_t0),
		.head_view(head_t0),
		.tag_0(t0_tag_0),
		.tag_1(t0_tag_1),
		.full(full_t0)
	);

	rob_thread_queue #(.THREAD_ID(1'b1)) queue_t1 (
		.clock(clock),
		.reset(reset),
		.dispatch(dispatch),
		.squash_any(squash_any),
		.complete_a(complete_a),
		.complete_b(complete_b),
		.retire_count(retire_t1),
		.squash(squash_t1),
		.head_view(head_t1),
		.tag_0(t1_tag_0),
		.tag_1(t1_tag_1),
		.full(full_t1)
	);

	rob_commit_select commit_select (
		.head_t0(head_t0),
		.head_t1(head_t1),
		.commit_0(commit_0),
		.commit_1(commit_1),
		.retire_t0(retire_t0),
		.retire_t1(retire_t1),
		.squash_t0(squash_t0),
		.squash_t1(squash_t1),
		.squash_any(squash_any)
	);

	// tags come from the queue of the dispatching thread
	assign tag_0 = dispatch.thread ? t1_tag_0 : t0_tag_0;
	assign tag_1 = dispatch.thread ? t1_tag_1 : t0_tag_1;

endmodule

// ==== rob/rob_commit_select.sv ====
`timescale 1ns/1ps
// commit selection for the two-thread reorder buffer
// picks up to two retirements from the thread heads,
// counts retirements per thread and raises squash on a mispredict
module rob_commit_select (
	input rob_pkg::head_view_t head_t0,
	input rob_pkg::head_view_t head_t1,
	output rob_pkg::commit_t commit_0,
	output rob_pkg::commit_t commit_1,
	output logic [1:0] retire_t0,
	output logic [1:0] retire_t1,
	output logic squash_t0,
	output logic squash_t1,
	output logic squash_any
);

	rob_pkg::head_slot_t same_next; // entry behind commit_0 in its thread
	logic bad_0; // commit_0 is a mispredicted branch
	logic bad_1;
	logic t0_on_0;
	logic t0_on_1;
	logic t1_on_0;
	logic t1_on_1;

	function automatic rob_pkg::commit_t to_commit(input rob_pkg::head_slot_t slot,
		input logic thread);
		rob_pkg::commit_t c;
		c.valid = 1'b1;
		c.thread = thread;
		c.entry = slot.entry;
		c.mispredict = slot.mispredict;
		c.target_pc = slot.target_pc;
		return c;
	endfunction

	always_comb
	begin
		commit_0 = '0;
		commit_1 = '0;

		// thread 0 has priority for the first port
		if (head_t0.head.ready)
			commit_0 = to_commit(head_t0.head, 1'b0);
		else if (head_t1.head.ready)
			commit_0 = to_commit(head_t1.head, 1'b1);

		bad_0 = commit_0.valid && commit_0.entry.is_branch && commit_0.mispredict;
		same_next = commit_0.thread ? head_t1.next : head_t0.next;

		if (commit_0.valid && same_next.ready && !bad_0)
			commit_1 = to_commit(same_next, commit_0.thread);
		else if (commit_0.valid && !commit_0.thread && head_t1.head.ready)
			commit_1 = to_commit(head_t1.head, 1'b1); // other thread fills the slot

		bad_1 = commit_1.valid && commit_1.entry.is_branch && commit_1.mispredict;
	end

	assign t0_on_0 = commit_0.valid && !commit_0.thread;
	assign t0_on_1 = commit_1.valid && !commit_1.thread;
	assign t1_on_0 = commit_0.valid && commit_0.thread;
	assign t1_on_1 = commit_1.valid && commit_1.thread;

	assign retire_t0 = {1'b0, t0_on_0} + {1'b0, t0_on_1};
	assign retire_t1 = {1'b0, t1_on_0} + {1'b0, t1_on_1};

	// a retiring mispredict flushes the rest of its own thread
	assign squash_t0 = (t0_on_0 && bad_0) || (t0_on_1 && bad_1);
	assign squash_t1 = (t1_on_0 && bad_0) || (t1_on_1 && bad_1);
	assign squash_any = squash_t0 || squash_t1;

endmodule

// ==== rob/rob_thread_queue.sv ====
`timescale 1ns/1ps
// per-thread reorder buffer queue
// entry storage with done, mispredict and target pc per slot
// head/tail pointers, completion decode, dispatch tags,
// squash recovery and full flag
module rob_thread_queue #(
	parameter logic THREAD_ID = 1'b0
)(
	input logic clock,
	input logic reset,
	input rob_pkg::dispatch_t dispatch,
	input logic squash_any,
	input rob_pkg::complete_t complete_a,
	input rob_pkg::complete_t complete_b,
	input logic [1:0] retire_count,
	input logic squash,
	output rob_pkg::head_view_t head_view,
	output rob_pkg::rob_tag_t tag_0,
	output rob_pkg::rob_tag_t tag_1,
	output logic full
);

	rob_pkg::rob_index_t head;
	rob_pkg::rob_index_t tail;
	rob_pkg::rob_index_t head_plus1;
	rob_pkg::rob_index_t tail_plus1;
	rob_pkg::rob_index_t tail_plus2;
	rob_pkg::rob_index_t next_head;
	rob_pkg::rob_index_t used; // occupied slots

	logic [rob_pkg::ROB_DEPTH-1:0] done;
	logic [rob_pkg::ROB_DEPTH-1:0] mispredict_mem;
	rob_pkg::rob_entry_t entry_mem [rob_pkg::ROB_DEPTH];
	logic [rob_pkg::PC_BITS-1:0] target_mem [rob_pkg::ROB_DEPTH];

	logic accept;
	logic write_0;
	logic write_1;
	logic [1:0] dispatch_count;
	logic hit_a;
	logic hit_b;
	logic retire_head;
	logic retire_next;

	assign head_plus1 = head + rob_pkg::rob_index_t'(1);
	assign tail_plus1 = tail + rob_pkg::rob_index_t'(1);
	assign tail_plus2 = tail + rob_pkg::rob_index_t'(2);
	assign next_head = head + rob_pkg::rob_index_t'(retire_count);
	assign used = tail - head;

	// one slot always stays empty so head == tail means empty
	assign full = (tail_plus1 == head) || (tail_plus2 == head);

	// no dispatch while a squash is being applied
	assign accept = (dispatch.thread == THREAD_ID) && !full && !squash_any;
	assign write_0 = accept && dispatch.valid_0;
	assign write_1 = accept && dispatch.valid_1;
	assign dispatch_count = {1'b0, write_0} + {1'b0, write_1};

	assign hit_a = complete_a.valid && (complete_a.tag.thread == THREAD_ID);
	assign hit_b = complete_b.valid && (complete_b.tag.thread == THREAD_ID);

	assign retire_head = |retire_count;
	assign retire_next = retire_count[1];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
		end
		else
		begin
			head <= next_head;
			if (squash)
				tail <= next_head; // younger entries are gone
			else
				tail <= tail + rob_pkg::rob_index_t'(dispatch_count);
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			done <= '0;
		else
		begin
			for (int i = 0; i < rob_pkg::ROB_DEPTH; i++)
			begin
				if ((write_0 && rob_pkg::rob_index_t'(i) == tail) ||
					(write_1 && rob_pkg::rob_index_t'(i) == tail_plus1))
					done[i] <= 1'b0; // new entry, not executed yet
				else if (hit_a && complete_a.tag.index == rob_pkg::rob_index_t'(i))
					done[i] <= 1'b1;
				else if (hit_b && complete_b.tag.index == rob_pkg::rob_index_t'(i))
					done[i] <= 1'b1;
				else if ((retire_head && rob_pkg::rob_index_t'(i) == head) ||
					(retire_next && rob_pkg::rob_index_t'(i) == head_plus1))
					done[i] <= 1'b0;
			end
		end
	end

	// payload, port a written last so it wins on a shared tag
	always_ff @(posedge clock)
	begin
		if (write_0)
			entry_mem[tail] <= dispatch.entry_0;
		if (write_1)
			entry_mem[tail_plus1] <= dispatch.entry_1;
		if (hit_b)
		begin
			mispredict_mem[complete_b.tag.index] <= complete_b.mispredict;
			target_mem[complete_b.tag.index] <= complete_b.target_pc;
		end
		if (hit_a)
		begin
			mispredict_mem[complete_a.tag.index] <= complete_a.mispredict;
			target_mem[complete_a.tag.index] <= complete_a.target_pc;
		end
	end

	always_comb
	begin
		head_view.head.ready = (used != '0) && done[head];
		head_view.head.entry = entry_mem[head];
		head_view.head.mispredict = mispredict_mem[head];
		head_view.head.target_pc = target_mem[head];

		head_view.next.ready = (used > rob_pkg::rob_index_t'(1)) && done[head_plus1];
		head_view.next.entry = entry_mem[head_plus1];
		head_view.next.mispredict = mispredict_mem[head_plus1];
		head_view.next.target_pc = target_mem[head_plus1];
	end

	// tags for the slots being dispatched this cycle
	always_comb
	begin
		tag_0 = '0;
		tag_1 = '0;
		if (dispatch.valid_0)
		begin
			tag_0.thread = THREAD_ID;
			tag_0.index = tail;
		end
		if (dispatch.valid_1)
		begin
			tag_1.thread = THREAD_ID;
			tag_1.index = tail_plus1;
		end
	end

endmodule

// ==== rob_top.f ====
common/rob_pkg.sv
rob/rob_thread_queue.sv
rob/rob_commit_select.sv
design/rob_top.sv
testbench/rob_assert.sv
testbench/rob_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the reorder buffer testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module rob_tb -f rob_top.f &&
output=$(./obj_dir/Vrob_tb 2>&1; true) &&
echo "$output" &&
echo "$output" | grep -qx "Simulation PASSED" ||
{ echo "reorder buffer simulation did not pass"; exit 1; }

// ==== testbench/rob_assert.sv ====
`timescale 1ns/1ps
// concurrent checks on the reorder buffer outputs
// reset state, commit port order, no same-thread commit after a mispredict
module rob_assert (
	input logic clock,
	input logic reset,
	input rob_pkg::commit_t commit_0,
	input rob_pkg::commit_t commit_1,
	input logic full_t0,
	input logic full_t1
);

	logic bad_0; // commit_0 is a mispredicted branch

	assign bad_0 = commit_0.valid && commit_0.entry.is_branch && commit_0.mispredict;

	// one reset edge clears every output
	reset_quiet: assert property (@(posedge clock) $past(reset) |->
		!commit_0.valid && !commit_1.valid && !full_t0 && !full_t1)
		else $error("commit or full output active during or right after reset");

	second_needs_first: assert property (@(posedge clock) disable iff (reset)
		commit_1.valid |-> commit_0.valid)
		else $error("commit_1 valid without commit_0");

	no_commit_after_mispredict: assert property (@(posedge clock) disable iff (reset)
		bad_0 |-> !(commit_1.valid && commit_1.thread == commit_0.thread))
		else $error("younger entry of a mispredicting thread committed");

endmodule

bind rob_top rob_assert assert_inst (
	.clock(clock),
	.reset(reset),
	.commit_0(commit_0),
	.commit_1(commit_1),
	.full_t0(full_t0),
	.full_t1(full_t1)
);

// ==== testbench/rob_tb.sv ====
`timescale 1ns/1ps
// reorder buffer testbench
// random dispatch and completion traffic against a per-thread model
// checks on tags, full flags and commits, watchdog
module rob_tb;

	localparam int DEPTH = rob_pkg::ROB_DEPTH;
	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int TEST_CYCLES = 4000;

	// one model slot with its completion state
	typedef struct packed {
		rob_pkg::rob_entry_t entry;
		logic done;
		logic mispredict;
		logic [rob_pkg::PC_BITS-1:0] target_pc;
	} model_slot_t;

	logic clock;
	logic reset;
	rob_pkg::dispatch_t dispatch;
	rob_pkg::complete_t complete_a;
	rob_pkg::complete_t complete_b;
	rob_pkg::rob_tag_t tag_0;
	rob_pkg::rob_tag_t tag_1;
	rob_pkg::commit_t commit_0;
	rob_pkg::commit_t commit_1;
	logic full_t0;
	logic full_t1;

	model_slot_t slots [2][DEPTH];
	rob_pkg::rob_index_t head [2];
	int count [2]; // outstanding entries per thread
	integer seed = 32'hd62f6534;

	rob_top uut (.*);

	initial
	begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic logic [31:0] random_word();
		return $random(seed);
	endfunction

	// slot k places behind the head modulo the queue depth
	function automatic rob_pkg::rob_index_t slot_at(input logic t, input int k);
		return rob_pkg::rob_index_t'((int'(head[t]) + k) % DEPTH);
	endfunction

	function automatic logic model_full(input logic t);
		return count[t] >= DEPTH - 2; // fewer than two of DEPTH-1 slots free
	endfunction

	function automatic rob_pkg::commit_t model_commit(input logic t, input int k);
		rob_pkg::commit_t c;
		model_slot_t s;
		s = slots[t][slot_at(t, k)];
		c.valid = (count[t] > k) && s.done;
		c.thread = t;
		c.entry = s.entry;
		c.mispredict = s.mispredict;
		c.target_pc = s.target_pc;
		return c;
	endfunction

	function automatic rob_pkg::rob_entry_t random_entry();
		rob_pkg::rob_entry_t e;
		logic [31:0] r;
		r = random_word();
		e.pc = {random_word(), random_word()};
		e.arn_dest = r[4:0];
		e.prn_dest = r[10:5];
		e.is_branch = (r[13:12] == 2'b00); // about one in four
		return e;
	endfunction

	// picks an outstanding entry that has not completed yet
	function automatic rob_pkg::complete_t random_completion();
		rob_pkg::complete_t c;
		logic [31:0] r;
		logic t;
		rob_pkg::rob_index_t slot;
		r = random_word();
		t = r[0];
		c = '0;
		if (r[3:1] < 3'd5 && count[t] > 0)
		begin
			slot = slot_at(t, int'(r[31:8]) % count[t]);
			if (!slots[t][slot].done)
			begin
				c.valid = 1'b1;
				c.tag = {t, slot};
				c.mispredict = slots[t][slot].entry.is_branch && (r[5:4] == 2'b00);
				c.target_pc = {random_word(), random_word()};
			end
		end
		return c;
	endfunction

	task automatic drive_stimulus();
		logic [31:0] r;
		r = random_word();
		dispatch.thread = r[0];
		dispatch.valid_0 = (r[2:1] != 2'b00);
		dispatch.valid_1 = dispatch.valid_0 && r[3]; // pairs and singles
		dispatch.entry_0 = random_entry();
		dispatch.entry_1 = random_entry();
		complete_a = random_completion();
		complete_b = random_completion();
	endtask

	task automatic record_completion(input rob_pkg::complete_t c);
		if (c.valid)
		begin
			slots[c.tag.thread][c.tag.index].done = 1'b1;
			slots[c.tag.thread][c.tag.index].mispredict = c.mispredict;
			slots[c.tag.thread][c.tag.index].target_pc = c.target_pc;
		end
	endtask

	task automatic record_dispatch(input logic t, input int k, input rob_pkg::rob_entry_t e);
		model_slot_t s;
		s = '0;
		s.entry = e;
		slots[t][slot_at(t, k)] = s;
	endtask

	task automatic retire_thread(input logic t, input rob_pkg::commit_t c0,
		input rob_pkg::commit_t c1);
		int n;
		logic squash;
		n = int'(c0.valid && c0.thread == t) + int'(c1.valid && c1.thread == t);
		squash = (c0.valid && c0.thread == t && c0.entry.is_branch && c0.mispredict) ||
			(c1.valid && c1.thread == t && c1.entry.is_branch && c1.mispredict);
		head[t] = slot_at(t, n);
		count[t] = squash ? 0 : count[t] - n; // younger entries are dropped
	endtask

	// model state after the coming edge
	task automatic advance_model(input rob_pkg::commit_t c0, input rob_pkg::commit_t c1);
		logic t;
		logic blocked;
		blocked = (c0.valid && c0.entry.is_branch && c0.mispredict) ||
			(c1.valid && c1.entry.is_branch && c1.mispredict);
		record_completion(complete_b);
		record_completion(complete_a); // port a wins on a shared tag
		t = dispatch.thread;
		if (!blocked && !model_full(t))
		begin
			if (dispatch.valid_0)
				record_dispatch(t, count[t], dispatch.entry_0);
			if (dispatch.valid_1)
				record_dispatch(t, count[t] + 1, dispatch.entry_1);
			count[t] = count[t] + int'(dispatch.valid_0) + int'(dispatch.valid_1);
		end
		retire_thread(1'b0, c0, c1);
		retire_thread(1'b1, c0, c1);
	endtask

	task automatic check_cycle();
		rob_pkg::rob_tag_t exp_tag_0;
		rob_pkg::rob_tag_t exp_tag_1;
		rob_pkg::commit_t head_0;
		rob_pkg::commit_t head_1;
		rob_pkg::commit_t follow;
		rob_pkg::commit_t exp_0;
		rob_pkg::commit_t exp_1;
		logic t;
		t = dispatch.thread;
		exp_tag_0 = '0;
		exp_tag_1 = '0;
		if (dispatch.valid_0)
			exp_tag_0 = {t, slot_at(t, count[t])};
		if (dispatch.valid_1)
			exp_tag_1 = {t, slot_at(t, count[t] + 1)};
		assert (tag_0 == exp_tag_0)
			else abort_run($sformatf("Fail tag_0: got %h, expected %h", tag_0, exp_tag_0));
		assert (tag_1 == exp_tag_1)
			else abort_run($sformatf("Fail tag_1: got %h, expected %h", tag_1, exp_tag_1));
		assert (full_t0 == model_full(1'b0))
			else abort_run($sformatf("Fail full_t0: got %h, expected %h",
				full_t0, model_full(1'b0)));
		assert (full_t1 == model_full(1'b1))
			else abort_run($sformatf("Fail full_t1: got %h, expected %h",
				full_t1, model_full(1'b1)));

		// thread 0 first, then the entry behind it unless a mispredict retires
		head_0 = model_commit(1'b0, 0);
		head_1 = model_commit(1'b1, 0);
		exp_0 = head_0.valid ? head_0 : head_1;
		follow = model_commit(exp_0.thread, 1);
		exp_1 = '0;
		if (exp_0.valid && follow.valid && !(exp_0.entry.is_branch && exp_0.mispredict))
			exp_1 = follow;
		else if (exp_0.valid && !exp_0.thread && head_1.valid)
			exp_1 = head_1;
		assert (commit_0.valid == exp_0.valid && (!exp_0.valid || commit_0 == exp_0))
			else abort_run($sformatf("Fail commit_0: got %h, expected %h", commit_0, exp_0));
		assert (commit_1.valid == exp_1.valid && (!exp_1.valid || commit_1 == exp_1))
			else abort_run($sformatf("Fail commit_1: got %h, expected %h", commit_1, exp_1));
		advance_model(exp_0, exp_1);
	endtask

	initial
	begin
		reset = 1'b1;
		dispatch = '0;
		complete_a = '0;
		complete_b = '0;
		head[0] = '0;
		head[1] = '0;
		count[0] = 0;
		count[1] = 0;
		for (int i = 1; i <= RESET_CYCLES; i++)
		begin
			@(posedge clock);
			#2;
			reset = (i < RESET_CYCLES);
			@(negedge clock);
			assert (!commit_0.valid && !commit_1.valid && !full_t0 && !full_t1)
				else abort_run($sformatf(
					"Fail reset: commit_0.valid %h commit_1.valid %h full_t0 %h full_t1 %h",
					commit_0.valid, commit_1.valid, full_t0, full_t1));
		end
		repeat (TEST_CYCLES)
		begin
			@(posedge clock);
			#2;
			drive_stimulus();
			@(negedge clock);
			check_cycle();
		end
		$display("Simulation PASSED");
		$finish;
	end

	// watchdog
	initial
	begin
		#((RESET_CYCLES + TEST_CYCLES + 20) * CLOCK_PERIOD);
		abort_run("Timeout: the test loop did not finish in time");
	end

endmodule
